/* sobel_macros.svh */
// *************************************************************************
// width and depth defines for the sobel edge filter.
// pixel, output lane, coordinate widths and line memory depth.
// *************************************************************************

`ifndef SOBEL_MACROS_SVH
`define SOBEL_MACROS_SVH

// greyscale input pixel.
`define SOBEL_PIX_W 8

// one lane of the output beat.
`define SOBEL_GRAD_W 16

// frame size and position counters.
`define SOBEL_COORD_W 11

// line memory depth with one entry per column.
`define SOBEL_MAX_X 2048

`endif

/* sobel_pkg.sv */
// *************************************************************************
// shared types for the sobel edge filter.
// pixel, gradient and coordinate types and the stage-to-stage structs.
// *************************************************************************

`include "sobel_macros.svh"

package sobel_pkg;

    typedef logic        [`SOBEL_PIX_W-1:0]   pix_t;
    typedef logic signed [`SOBEL_GRAD_W-1:0]  grad_t;
    typedef logic        [`SOBEL_COORD_W-1:0] coord_t;

    // one window column with the top row first.
    typedef struct packed {
        pix_t top;
        pix_t mid;
        pix_t bot;
    } col_t;

    typedef struct packed {
        col_t left;
        col_t centre;
        col_t right;
    } win_t;

    typedef struct packed {
        logic ok;      // interior window.
        logic first;   // first output of frame.
        logic last;    // last output of row.
    } tag_t;

    // lane 0 (lsb) holds dx and lane 2 the centre pixel.
    typedef struct packed {
        grad_t centre;
        grad_t dy;
        grad_t dx;
    } result_t;

endpackage

/* sobel_line_buffer.sv */
// *************************************************************************
// input side of the sobel filter.
// stream acceptance, x/y tracking, two row memories, column output.
// *************************************************************************

`timescale 1ns/1ps
`include "sobel_macros.svh"

module sobel_line_buffer import sobel_pkg::*; (
    input  logic   aclk,
    input  logic   arst_n_i,
    input  logic   adv_i,
    input  coord_t img_width_i,
    input  coord_t img_height_i,
    input  pix_t   s_tdata_i,
    input  logic   s_tuser_i,
    input  logic   s_tvalid_i,
    output col_t   col_o,
    output coord_t x_o,
    output coord_t y_o,
    output logic   row_end_o,
    output logic   frame_start_o,
    output logic   col_valid_o
);

    logic   accept;
    coord_t width_r;
    coord_t height_r;
    coord_t cnt_x;
    coord_t cnt_y;
    coord_t width;
    coord_t height;
    coord_t pos_x;
    coord_t pos_y;
    logic   at_row_end;
    logic   at_frame_end;
    pix_t   row1_mem [`SOBEL_MAX_X];
    pix_t   row2_mem [`SOBEL_MAX_X];
    pix_t   row1_rd;
    pix_t   row2_rd;

    assign accept = adv_i & s_tvalid_i;

    // a tuser beat takes the new size and sits at the origin.
    assign width  = s_tuser_i ? img_width_i : width_r;
    assign height = s_tuser_i ? img_height_i : height_r;
    assign pos_x  = s_tuser_i ? '0 : cnt_x;
    assign pos_y  = s_tuser_i ? '0 : cnt_y;

    assign at_row_end   = (pos_x == width - 1'b1);
    assign at_frame_end = at_row_end & (pos_y == height - 1'b1);

    assign row1_rd = row1_mem[pos_x];   // row y-1.
    assign row2_rd = row2_mem[pos_x];   // row y-2.

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            width_r  <= '0;
            height_r <= '0;
            cnt_x    <= '0;
            cnt_y    <= '0;
        end else if (accept) begin
            if (s_tuser_i) begin
                width_r  <= img_width_i;
                height_r <= img_height_i;
            end
            if (at_frame_end) begin
                cnt_x <= '0;
                cnt_y <= '0;
            end else if (at_row_end) begin
                cnt_x <= '0;
                cnt_y <= pos_y + 1'b1;
            end else begin
                cnt_x <= pos_x + 1'b1;
                cnt_y <= pos_y;
            end
        end
    end

    // row-1 ages into row-2 at the same column.
    always_ff @(posedge aclk) begin
        if (accept) begin
            row1_mem[pos_x] <= s_tdata_i;
            row2_mem[pos_x] <= row1_rd;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            col_o <= '{top: row2_rd, mid: row1_rd, bot: s_tdata_i};
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            col_valid_o   <= 1'b0;
            x_o           <= '0;
            y_o           <= '0;
            row_end_o     <= 1'b0;
            frame_start_o <= 1'b0;
        end else if (adv_i) begin
            col_valid_o <= s_tvalid_i;
            if (s_tvalid_i) begin
                x_o           <= pos_x;
                y_o           <= pos_y;
                row_end_o     <= at_row_end;
                frame_start_o <= s_tuser_i;
            end
        end
    end

endmodule

/* sobel_window.sv */
// *************************************************************************
// 3x3 window of the sobel filter.
// column shift register and interior, frame start and row end tags.
// *************************************************************************

`timescale 1ns/1ps

module sobel_window import sobel_pkg::*; (
    input  logic   aclk,
    input  logic   arst_n_i,
    input  logic   adv_i,
    input  col_t   col_i,
    input  coord_t x_i,
    input  coord_t y_i,
    input  logic   row_end_i,
    input  logic   frame_start_i,
    input  logic   col_valid_i,
    output win_t   win_o,
    output tag_t   tag_o,
    output logic   win_valid_o
);

    logic shift;
    logic in_frame;
    logic live;
    logic interior;
    logic at_origin;

    assign shift = adv_i & col_valid_i;

    // nothing counts until the first tuser after reset.
    assign live = frame_start_i | in_frame;

    // the window centre sits one pixel up and left of (x, y).
    assign interior  = live & (x_i >= coord_t'(2)) & (y_i >= coord_t'(2));
    assign at_origin = live & (x_i == coord_t'(2)) & (y_i == coord_t'(2));

    always_ff @(posedge aclk) begin
        if (shift) begin
            win_o.left   <= win_o.centre;
            win_o.centre <= win_o.right;
            win_o.right  <= col_i;
        end
    end

    always_ff @(posedge aclk) begin
        if (shift) begin
            tag_o.ok    <= interior;
            tag_o.first <= at_origin;
            tag_o.last  <= interior & row_end_i;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            win_valid_o <= 1'b0;
            in_frame    <= 1'b0;
        end else if (adv_i) begin
            win_valid_o <= col_valid_i;
            if (col_valid_i && frame_start_i) begin
                in_frame <= 1'b1;
            end
        end
    end

endmodule

/* sobel_gradient.sv */
// *************************************************************************
// sobel gradient pipeline, two stages.
// first stage with the 1-2-1 weighted column and row sums.
// second stage with dx, dy and the zero-extended centre pixel.
// *************************************************************************

`timescale 1ns/1ps
`include "sobel_macros.svh"

module sobel_gradient import sobel_pkg::*; (
    input  logic    aclk,
    input  logic    arst_n_i,
    input  logic    adv_i,
    input  win_t    win_i,
    input  tag_t    tag_i,
    input  logic    win_valid_i,
    output result_t res_o,
    output tag_t    tag_o,
    output logic    res_valid_o
);

    logic [`SOBEL_PIX_W+1:0] sum_l_q;
    logic [`SOBEL_PIX_W+1:0] sum_r_q;
    logic [`SOBEL_PIX_W+1:0] sum_t_q;
    logic [`SOBEL_PIX_W+1:0] sum_b_q;
    pix_t                    centre_q;
    tag_t                    tag_q;
    logic                    valid_q;

    // a + 2b + c grows by two bits to 1020 at most.
    function automatic logic [`SOBEL_PIX_W+1:0] wsum(input pix_t a, input pix_t b,
                                                    input pix_t c);
        wsum = {2'b00, a} + {1'b0, b, 1'b0} + {2'b00, c};
    endfunction

    always_ff @(posedge aclk) begin
        if (adv_i) begin
            sum_l_q  <= wsum(win_i.left.top, win_i.left.mid, win_i.left.bot);
            sum_r_q  <= wsum(win_i.right.top, win_i.right.mid, win_i.right.bot);
            sum_t_q  <= wsum(win_i.left.top, win_i.centre.top, win_i.right.top);
            sum_b_q  <= wsum(win_i.left.bot, win_i.centre.bot, win_i.right.bot);
            centre_q <= win_i.centre.mid;
            tag_q    <= tag_i;
        end
    end

    // unsigned sums widen with zeros, so the difference is signed.
    always_ff @(posedge aclk) begin
        if (adv_i) begin
            res_o.dx     <= grad_t'(sum_r_q) - grad_t'(sum_l_q);
            res_o.dy     <= grad_t'(sum_b_q) - grad_t'(sum_t_q);
            res_o.centre <= grad_t'(centre_q);
            tag_o        <= tag_q;
        end
    end

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q     <= 1'b0;
            res_valid_o <= 1'b0;
        end else if (adv_i) begin
            valid_q     <= win_valid_i;
            res_valid_o <= valid_q;
        end
    end

endmodule

/* sobel_out_stage.sv */
// *************************************************************************
// output side of the sobel filter.
// result register, master stream and the pipeline advance enable.
// *************************************************************************

`timescale 1ns/1ps

module sobel_out_stage import sobel_pkg::*; (
    input  logic    aclk,
    input  logic    arst_n_i,
    input  result_t res_i,
    input  tag_t    tag_i,
    input  logic    res_valid_i,
    output logic    adv_o,
    output result_t m_tdata_o,
    output logic    m_tuser_o,
    output logic    m_tlast_o,
    output logic    m_tvalid_o,
    input  logic    m_tready_i
);

    logic load;

    // the whole pipeline moves when this register can take a beat.
    assign adv_o = ~m_tvalid_o | m_tready_i;

    // border windows are dropped here.
    assign load = adv_o & res_valid_i & tag_i.ok;

    always_ff @(posedge aclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            m_tvalid_o <= 1'b0;
        end else if (adv_o) begin
            m_tvalid_o <= res_valid_i & tag_i.ok;
        end
    end

    always_ff @(posedge aclk) begin
        if (load) begin
            m_tdata_o <= res_i;
            m_tuser_o <= tag_i.first;   // start of output frame.
            m_tlast_o <= tag_i.last;    // end of output row.
        end
    end

endmodule

/* sobel_top.sv */
// *************************************************************************
// sobel edge filter top level.
// line buffer, window, gradient and output stage in one pipeline.
// *************************************************************************

`timescale 1ns/1ps

module sobel_top import sobel_pkg::*; (
    input  logic    aclk,
    input  logic    arst_n_i,
    input  coord_t  img_width_i,
    input  coord_t  img_height_i,
    input  pix_t    s_tdata_i,
    input  logic    s_tuser_i,
    input  logic    s_tlast_i,      // row end comes from the width count.
    input  logic    s_tvalid_i,
    output logic    s_tready_o,
    output result_t m_tdata_o,
    output logic    m_tuser_o,
    output logic    m_tlast_o,
    output logic    m_tvalid_o,
    input  logic    m_tready_i
);

    logic    adv;
    col_t    col;
    coord_t  col_x;
    coord_t  col_y;
    logic    col_row_end;
    logic    col_frame_start;
    logic    col_valid;
    win_t    win;
    tag_t    win_tag;
    logic    win_valid;
    result_t res;
    tag_t    res_tag;
    logic    res_valid;

    assign s_tready_o = adv;   // one stall for every stage.

    sobel_line_buffer u_line_buffer (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .adv_i         (adv),
        .img_width_i   (img_width_i),
        .img_height_i  (img_height_i),
        .s_tdata_i     (s_tdata_i),
        .s_tuser_i     (s_tuser_i),
        .s_tvalid_i    (s_tvalid_i),
        .col_o         (col),
        .x_o           (col_x),
        .y_o           (col_y),
        .row_end_o     (col_row_end),
        .frame_start_o (col_frame_start),
        .col_valid_o   (col_valid)
    );

    sobel_window u_window (
        .aclk          (aclk),
        .arst_n_i      (arst_n_i),
        .adv_i         (adv),
        .col_i         (col),
        .x_i           (col_x),
        .y_i           (col_y),
        .row_end_i     (col_row_end),
        .frame_start_i (col_frame_start),
        .col_valid_i   (col_valid),
        .win_o         (win),
        .tag_o         (win_tag),
        .win_valid_o   (win_valid)
    );

    sobel_gradient u_gradient (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .adv_i       (adv),
        .win_i       (win),
        .tag_i       (win_tag),
        .win_valid_i (win_valid),
        .res_o       (res),
        .tag_o       (res_tag),
        .res_valid_o (res_valid)
    );

    sobel_out_stage u_out_stage (
        .aclk        (aclk),
        .arst_n_i    (arst_n_i),
        .res_i       (res),
        .tag_i       (res_tag),
        .res_valid_i (res_valid),
        .adv_o       (adv),
        .m_tdata_o   (m_tdata_o),
        .m_tuser_o   (m_tuser_o),
        .m_tlast_o   (m_tlast_o),
        .m_tvalid_o  (m_tvalid_o),
        .m_tready_i  (m_tready_i)
    );

endmodule

/* tb_sobel.sv */
// ***************************************************************************
// testbench for the sobel edge filter.
// random frames with input gaps and output back-pressure,
// reference model, per-beat checks and the final report.
// ***************************************************************************

`timescale 1ns/1ps

module tb_sobel import sobel_pkg::*; ();

    localparam int FRAMES = 4;

    typedef struct packed {
        grad_t dx;
        grad_t dy;
        grad_t centre;
        logic  first;
        logic  last;
    } beat_t;

    typedef struct packed {
        int id;
        int w;
        int h;
        int beats;
    } frame_info_t;

    logic    aclk = 1'b0;
    logic    arst_n_i;
    coord_t  img_width_i;
    coord_t  img_height_i;
    pix_t    s_tdata_i;
    logic    s_tuser_i;
    logic    s_tlast_i;
    logic    s_tvalid_i;
    logic    s_tready_o;
    result_t m_tdata_o;
    logic    m_tuser_o;
    logic    m_tlast_o;
    logic    m_tvalid_o;
    logic    m_tready_i;

    pix_t        img[$];         // current frame in raster order.
    int          img_w;
    beat_t       exp_q[$];
    frame_info_t frame_q[$];
    bit          ready_pat[$];   // pre-drawn m_tready_i pattern.
    int          timeout_cycles;
    int          cycles;
    int          checks;
    int          errors;
    int          beats_seen;
    int          frame_got;
    int          frame_err_base;

    always #5 aclk = ~aclk;

    sobel_top dut (
        .aclk         (aclk),
        .arst_n_i     (arst_n_i),
        .img_width_i  (img_width_i),
        .img_height_i (img_height_i),
        .s_tdata_i    (s_tdata_i),
        .s_tuser_i    (s_tuser_i),
        .s_tlast_i    (s_tlast_i),
        .s_tvalid_i   (s_tvalid_i),
        .s_tready_o   (s_tready_o),
        .m_tdata_o    (m_tdata_o),
        .m_tuser_o    (m_tuser_o),
        .m_tlast_o    (m_tlast_o),
        .m_tvalid_o   (m_tvalid_o),
        .m_tready_i   (m_tready_i)
    );

    function automatic int frame_w(input int f);
        case (f)
            0:       return 8;
            1:       return 16;
            2:       return 3;
            default: return 5;
        endcase
    endfunction

    function automatic int frame_h(input int f);
        case (f)
            0:       return 5;
            1:       return 6;
            2:       return 3;
            default: return 12;
        endcase
    endfunction

    function automatic int px(input int x, input int y);
        return int'(img[y * img_w + x]);
    endfunction

    task automatic check_value(input string name, input int exp_v, input int act_v);
        checks++;
        if (exp_v != act_v) begin
            $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
            errors++;
        end
    endtask

    // draws one frame and queues its interior windows.
    task automatic build_frame(input int f);
        int          fw;
        int          fh;
        int          sel;
        int          v;
        int          sl;
        int          sr;
        int          st;
        int          sb;
        beat_t       b;
        frame_info_t fi;
        fw = frame_w(f);
        fh = frame_h(f);
        img.delete();
        img_w = fw;
        for (int y = 0; y < fh; y++) begin
            for (int x = 0; x < fw; x++) begin
                sel = int'($urandom % 4);
                if (f == 1 && sel < 2) begin
                    v = (x < fw / 2) ? 0 : 255;   // vertical step edge.
                end else if (sel == 0) begin
                    v = 0;
                end else if (sel == 1) begin
                    v = 255;
                end else begin
                    v = int'($urandom % 256);
                end
                img.push_back(pix_t'(v));
            end
        end
        for (int cy = 1; cy < fh - 1; cy++) begin
            for (int cx = 1; cx < fw - 1; cx++) begin
                sl = px(cx - 1, cy - 1) + 2 * px(cx - 1, cy) + px(cx - 1, cy + 1);
                sr = px(cx + 1, cy - 1) + 2 * px(cx + 1, cy) + px(cx + 1, cy + 1);
                st = px(cx - 1, cy - 1) + 2 * px(cx, cy - 1) + px(cx + 1, cy - 1);
                sb = px(cx - 1, cy + 1) + 2 * px(cx, cy + 1) + px(cx + 1, cy + 1);
                b.dx     = grad_t'(sr - sl);
                b.dy     = grad_t'(sb - st);
                b.centre = grad_t'(px(cx, cy));
                b.first  = (cx == 1) && (cy == 1);
                b.last   = (cx == fw - 2);
                exp_q.push_back(b);
            end
        end
        fi.id    = f;
        fi.w     = fw;
        fi.h     = fh;
        fi.beats = (fw - 2) * (fh - 2);
        frame_q.push_back(fi);
    endtask

    // entered and left 1 ns after a rising edge.
    task automatic send_frame(input int f);
        int fw;
        int fh;
        build_frame(f);
        fw = frame_w(f);
        fh = frame_h(f);
        img_width_i  = coord_t'(fw);
        img_height_i = coord_t'(fh);
        for (int y = 0; y < fh; y++) begin
            for (int x = 0; x < fw; x++) begin
                while (($urandom % 4) == 0) begin
                    s_tvalid_i = 1'b0;   // input gap.
                    @(posedge aclk);
                    #1;
                end
                s_tvalid_i = 1'b1;
                s_tdata_i  = img[y * fw + x];
                s_tuser_i  = (x == 0) && (y == 0);
                s_tlast_i  = (x == fw - 1);
                @(negedge aclk);
                while (!s_tready_o) begin
                    @(negedge aclk);
                end
                @(posedge aclk);
                #1;
            end
        end
    endtask

    // output monitor sampling mid-cycle.
    always @(negedge aclk) begin
        beat_t exp_b;
        if (arst_n_i && m_tvalid_o && m_tready_i) begin
            beats_seen++;
            if (exp_q.size() == 0) begin
                $display("unexpected output beat at %0t with nothing left to expect", $time);
                errors++;
            end else begin
                exp_b = exp_q.pop_front();
                check_value("m_tdata_o.dx", int'(exp_b.dx), int'(m_tdata_o.dx));
                check_value("m_tdata_o.dy", int'(exp_b.dy), int'(m_tdata_o.dy));
                check_value("m_tdata_o.centre", int'(exp_b.centre), int'(m_tdata_o.centre));
                check_value("m_tuser_o", int'(exp_b.first), int'(m_tuser_o));
                check_value("m_tlast_o", int'(exp_b.last), int'(m_tlast_o));
                frame_got++;
                if (frame_got == frame_q[0].beats) begin
                    $display("frame %0d (%0dx%0d): %0d beats, %0d errors", frame_q[0].id,
                             frame_q[0].w, frame_q[0].h, frame_got, errors - frame_err_base);
                    frame_err_base = errors;
                    frame_got = 0;
                    void'(frame_q.pop_front());
                end
            end
        end
    end

    initial begin
        m_tready_i = 1'b1;
        @(posedge arst_n_i);
        for (int k = 0; ; k++) begin
            @(posedge aclk);
            #1;
            m_tready_i = ready_pat[k % ready_pat.size()];
        end
    end

    initial begin
        cycles = 0;
        @(posedge arst_n_i);
        while (cycles < timeout_cycles) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout after %0d cycles, %0d expected output beats never arrived",
                 cycles, exp_q.size());
        $display("** FAIL **");
        $finish;
    end

    initial begin
        int total_pix;
        void'($urandom(32'h19ba4731));
        arst_n_i     = 1'b0;
        img_width_i  = '0;
        img_height_i = '0;
        s_tdata_i    = '0;
        s_tuser_i    = 1'b0;
        s_tlast_i    = 1'b0;
        s_tvalid_i   = 1'b0;
        checks       = 0;
        errors       = 0;
        beats_seen   = 0;
        frame_got    = 0;
        frame_err_base = 0;
        total_pix    = 0;
        for (int f = 0; f < FRAMES; f++) begin
            total_pix += frame_w(f) * frame_h(f);
        end
        timeout_cycles = 4 * total_pix + 200;
        for (int i = 0; i < 4096; i++) begin
            ready_pat.push_back(($urandom % 10) >= 3);   // about 30% low.
        end
        repeat (10) @(posedge aclk);
        #1;
        arst_n_i = 1'b1;
        @(negedge aclk);
        check_value("m_tvalid_o", 0, int'(m_tvalid_o));
        check_value("s_tready_o", 1, int'(s_tready_o));
        $display("reset: %0d errors", errors);
        frame_err_base = errors;
        @(posedge aclk);
        #1;
        for (int f = 0; f < FRAMES; f++) begin
            send_frame(f);
        end
        s_tvalid_i = 1'b0;
        s_tuser_i  = 1'b0;
        s_tlast_i  = 1'b0;
        while (exp_q.size() != 0) begin
            @(posedge aclk);
        end
        repeat (20) @(posedge aclk);   // catch any extra beats.
        $display("done: %0d frames, %0d beats, %0d checks, %0d errors",
                 FRAMES, beats_seen, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* vlog.f */
+incdir+.
sobel_pkg.sv
sobel_line_buffer.sv
sobel_window.sv
sobel_gradient.sv
sobel_out_stage.sv
sobel_top.sv
tb_sobel.sv

/* Makefile */
TOOL  := verilator
FLAGS := --binary --timing
TOP   := tb_sobel
FLIST := vlog.f

OBJ_DIR := obj_dir
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

# build and run, then look for the pass line in the output
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
